/* design/zet_bus_cfg.svh */
// widths for the bus interface; byte addresses are 20 bits and the data bus is 16 bits
`ifndef ZET_BUS_CFG_SVH
`define ZET_BUS_CFG_SVH

// physical byte address, real mode 1 MB
`define ZB_ADR_W 20

// data bus width, two byte lanes
`define ZB_DAT_W 16

// bus sequencer state register
`define ZB_ST_W 2

// word address width on the Wishbone side
`define ZB_WADR_W (`ZB_ADR_W - 1)

`endif

/* design/wb_pkg.sv */
// wishbone classic bundles; word addressed, 16-bit data, no burst tags
`include "zet_bus_cfg.svh"

package wb_pkg;

  // master outputs, one cycle per strobe
  typedef struct packed {
    logic [`ZB_WADR_W-1:0] adr; // word address, byte bit dropped
    logic [`ZB_DAT_W-1:0]  dat; // write data, lanes already swapped
    logic                  we;
    logic                  tga; // high for i/o space
    logic [1:0]            sel; // lane selects, bit 1 is the high byte
    logic                  stb;
    logic                  cyc;
  } wb_m2s_t;

  // slave returns
  typedef struct packed {
    logic [`ZB_DAT_W-1:0] dat; // read data
    logic                 ack; // one cycle per strobe
  } wb_s2m_t;

endpackage

/* design/zet_bus_pkg.sv */
// core side types for the bus interface; one access in flight at a time
`include "zet_bus_cfg.svh"

package zet_bus_pkg;

  // the access chosen between fetch and execute
  typedef struct packed {
    logic                  op;       // access wanted
    logic [`ZB_WADR_W-1:0] adr_lo;   // first word
    logic [`ZB_WADR_W-1:0] adr_hi;   // next word, same word when even
    logic                  a0;       // odd byte address
    logic                  byte_op;
    logic                  odd_word; // word straddling two bus words
    logic                  we;
    logic                  io;
    logic [`ZB_DAT_W-1:0]  wdat;
  } access_req_t;

  // bus sequencer states
  typedef enum logic [`ZB_ST_W-1:0] {
    ST_IDLE,    // first strobe follows op
    ST_STB1_LO, // second strobe of a split word
    ST_STB2_HI  // strobe dropped, waits for ack to clear
  } bus_state_e;

  // what the read register does with the bus data this cycle
  typedef enum logic [1:0] {
    CAP_NONE,  // hold
    CAP_FIRST, // load per a0 and byte_op
    CAP_HIGH   // bus low byte into the high byte
  } capture_e;

endpackage

/* design/access_select.sv */
// fetch accesses are treated as memory reads; the core holds its inputs while blocked
`timescale 1ns/10ps
`include "zet_bus_cfg.svh"

module access_select (
  input  logic [`ZB_ADR_W-1:0]     fetch_adr_i,
  input  logic                     fetch_byte_i,
  input  logic [`ZB_ADR_W-1:0]     exec_adr_i,
  input  logic                     exec_byte_i,
  input  logic                     exec_we_i,
  input  logic                     exec_io_i,
  input  logic [`ZB_DAT_W-1:0]     exec_dat_i,
  input  logic                     fetch_or_exec_i, // high selects execute
  input  logic                     memop_i,
  output zet_bus_pkg::access_req_t req_o
);

  logic [`ZB_ADR_W-1:0]  adr;
  logic                  byte_op;
  logic                  we;
  logic                  io;
  logic [`ZB_WADR_W-1:0] adr_word;
  logic [`ZB_WADR_W-1:0] adr_next;

  // requester mux
  always_comb
  begin
    if (fetch_or_exec_i)
    begin
      adr     = exec_adr_i;
      byte_op = exec_byte_i;
      we      = exec_we_i;
      io      = exec_io_i;
    end
    else
    begin
      adr     = fetch_adr_i;
      byte_op = fetch_byte_i;
      we      = 1'b0; // instruction fetch never writes
      io      = 1'b0;
    end
  end

  assign adr_word = adr[`ZB_ADR_W-1:1];
  assign adr_next = adr_word + {{(`ZB_WADR_W-1){1'b0}}, 1'b1};

  always_comb
  begin
    req_o.op       = memop_i | io;
    req_o.a0       = adr[0];
    req_o.byte_op  = byte_op;
    req_o.odd_word = adr[0] & ~byte_op;
    req_o.adr_lo   = adr_word;
    // second half only differs for odd addresses
    req_o.adr_hi   = adr[0] ? adr_next : adr_word;
    req_o.we       = we;
    req_o.io       = io;
    req_o.wdat     = exec_dat_i; // only execute writes
  end

endmodule

/* design/wb_access_fsm.sv */
// slave must ack exactly once per strobe; request must stay steady while block_o is high
`timescale 1ns/10ps

module wb_access_fsm (
  input  logic                     wb_clk_i,
  input  logic                     arst_n_i,
  input  zet_bus_pkg::access_req_t req_i,
  input  logic                     wb_ack_i,
  output wb_pkg::wb_m2s_t          m2s_o,
  output logic                     block_o,
  output zet_bus_pkg::capture_e    capture_o
);

  zet_bus_pkg::bus_state_e state_q;
  zet_bus_pkg::bus_state_e state_d;
  logic [1:0]              sel_first;

  // first strobe lanes: odd starts on the high lane
  always_comb
  begin
    if (req_i.a0)
      sel_first = 2'b10;
    else if (req_i.byte_op)
      sel_first = 2'b01;
    else
      sel_first = 2'b11;
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_q <= zet_bus_pkg::ST_IDLE;
    else
      state_q <= state_d;
  end

  // next state
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      zet_bus_pkg::ST_STB1_LO:
      begin
        if (wb_ack_i)
          state_d = zet_bus_pkg::ST_STB2_HI;
      end
      zet_bus_pkg::ST_STB2_HI:
      begin
        if (!wb_ack_i)
          state_d = zet_bus_pkg::ST_IDLE; // ack gone, core may move on
      end
      default:
      begin
        state_d = zet_bus_pkg::ST_IDLE;
        if (wb_ack_i && req_i.op)
          state_d = req_i.odd_word ? zet_bus_pkg::ST_STB1_LO : zet_bus_pkg::ST_STB2_HI;
      end
    endcase
  end

  // bus outputs and core stall
  always_comb
  begin
    m2s_o.we  = req_i.we;
    m2s_o.tga = req_i.io;
    // lanes swap when the access starts on an odd byte
    m2s_o.dat = req_i.a0 ? {req_i.wdat[7:0], req_i.wdat[15:8]} : req_i.wdat;
    capture_o = zet_bus_pkg::CAP_NONE;
    case (state_q)
      zet_bus_pkg::ST_STB1_LO:
      begin
        m2s_o.adr = req_i.adr_hi;
        m2s_o.sel = 2'b01;
        m2s_o.stb = 1'b1;
        m2s_o.cyc = 1'b1;
        block_o   = 1'b1;
        if (wb_ack_i)
          capture_o = zet_bus_pkg::CAP_HIGH;
      end
      zet_bus_pkg::ST_STB2_HI:
      begin
        m2s_o.adr = req_i.adr_hi;
        m2s_o.sel = 2'b01;
        m2s_o.stb = 1'b0;
        m2s_o.cyc = 1'b0;
        block_o   = wb_ack_i; // hold core until ack drops
      end
      default:
      begin
        m2s_o.adr = req_i.adr_lo;
        m2s_o.sel = sel_first;
        m2s_o.stb = req_i.op; // same cycle as the request
        m2s_o.cyc = req_i.op;
        block_o   = req_i.op;
        if (wb_ack_i)
          capture_o = zet_bus_pkg::CAP_FIRST;
      end
    endcase
  end

endmodule

/* design/read_assembler.sv */
// read data is valid the cycle after the last ack; iid path is raw bus data while inta_i is high
`timescale 1ns/10ps
`include "zet_bus_cfg.svh"

module read_assembler (
  input  logic                     wb_clk_i,
  input  logic                     arst_n_i,
  input  zet_bus_pkg::access_req_t req_i,
  input  zet_bus_pkg::capture_e    capture_i,
  input  logic [`ZB_DAT_W-1:0]     wb_dat_i,
  input  logic                     inta_i,
  output logic [`ZB_DAT_W-1:0]     cpu_dat_o,
  output logic [`ZB_DAT_W-1:0]     iid_dat_o
);

  localparam int unsigned HALF = `ZB_DAT_W / 2;

  logic [`ZB_DAT_W-1:0] dat_q;
  logic [`ZB_DAT_W-1:0] blw; // low lane, sign extended
  logic [`ZB_DAT_W-1:0] bhw; // high lane, sign extended
  logic [`ZB_DAT_W-1:0] first_dat;

  assign blw = {{HALF{wb_dat_i[HALF-1]}}, wb_dat_i[HALF-1:0]};
  assign bhw = {{HALF{wb_dat_i[`ZB_DAT_W-1]}}, wb_dat_i[`ZB_DAT_W-1:HALF]};

  // odd word also starts here; its high byte is overwritten later
  always_comb
  begin
    if (req_i.a0)
      first_dat = bhw;
    else if (req_i.byte_op)
      first_dat = blw;
    else
      first_dat = wb_dat_i;
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      dat_q <= '0;
    else
    begin
      case (capture_i)
        zet_bus_pkg::CAP_FIRST:
          dat_q <= first_dat;
        zet_bus_pkg::CAP_HIGH:
          dat_q <= {wb_dat_i[HALF-1:0], dat_q[HALF-1:0]}; // merge second half
        default:
          dat_q <= dat_q;
      endcase
    end
  end

  assign cpu_dat_o = dat_q;

  // vector number comes straight off the bus during inta
  assign iid_dat_o = inta_i ? wb_dat_i : dat_q;

endmodule

/* design/zet_bus_if.sv */
// bus side of the core; one access at a time, odd words take two wishbone cycles
`timescale 1ns/10ps
`include "zet_bus_cfg.svh"

module zet_bus_if (
  input  logic                  wb_clk_i,
  input  logic                  arst_n_i,
  // core side
  input  logic [`ZB_ADR_W-1:0]  fetch_adr_i,
  input  logic                  fetch_byte_i,
  input  logic [`ZB_ADR_W-1:0]  exec_adr_i,
  input  logic                  exec_byte_i,
  input  logic                  exec_we_i,
  input  logic                  exec_io_i,
  input  logic [`ZB_DAT_W-1:0]  exec_dat_i,
  input  logic                  fetch_or_exec_i,
  input  logic                  memop_i,
  input  logic                  inta_i,
  output logic [`ZB_DAT_W-1:0]  cpu_dat_o,
  output logic [`ZB_DAT_W-1:0]  iid_dat_o,
  output logic                  block_o,
  // wishbone master
  input  logic [`ZB_DAT_W-1:0]  wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  wb_tgc_i,  // intr, handled by the interrupt logic outside
  output logic [`ZB_DAT_W-1:0]  wb_dat_o,
  output logic [`ZB_ADR_W-1:1]  wb_adr_o,
  output logic                  wb_we_o,
  output logic                  wb_tga_o,  // io/mem
  output logic [1:0]            wb_sel_o,
  output logic                  wb_stb_o,
  output logic                  wb_cyc_o,
  output logic                  wb_tgc_o   // inta
);

  zet_bus_pkg::access_req_t req;
  zet_bus_pkg::capture_e    capture;
  wb_pkg::wb_m2s_t          m2s;
  wb_pkg::wb_s2m_t          s2m;

  assign s2m.dat = wb_dat_i;
  assign s2m.ack = wb_ack_i;

  access_select u_select (
    .fetch_adr_i     (fetch_adr_i),
    .fetch_byte_i    (fetch_byte_i),
    .exec_adr_i      (exec_adr_i),
    .exec_byte_i     (exec_byte_i),
    .exec_we_i       (exec_we_i),
    .exec_io_i       (exec_io_i),
    .exec_dat_i      (exec_dat_i),
    .fetch_or_exec_i (fetch_or_exec_i),
    .memop_i         (memop_i),
    .req_o           (req)
  );

  wb_access_fsm u_fsm (
    .wb_clk_i  (wb_clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (req),
    .wb_ack_i  (s2m.ack),
    .m2s_o     (m2s),
    .block_o   (block_o),
    .capture_o (capture)
  );

  read_assembler u_rdat (
    .wb_clk_i  (wb_clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (req),
    .capture_i (capture),
    .wb_dat_i  (s2m.dat),
    .inta_i    (inta_i),
    .cpu_dat_o (cpu_dat_o),
    .iid_dat_o (iid_dat_o)
  );

  assign wb_dat_o = m2s.dat;
  assign wb_adr_o = m2s.adr;
  assign wb_we_o  = m2s.we;
  assign wb_tga_o = m2s.tga;
  assign wb_sel_o = m2s.sel;
  assign wb_stb_o = m2s.stb;
  assign wb_cyc_o = m2s.cyc;
  assign wb_tgc_o = inta_i;

endmodule

/* tests/wb_mem_model.sv */
// wishbone slave for simulation; only byte addresses 0x000 to 0x1ff exist, i/o space maps onto memory
`timescale 1ns/10ps
`include "zet_bus_cfg.svh"

module wb_mem_model #(
  parameter logic [16:0] SEED   = 17'd76664,
  parameter logic [15:0] VECTOR = 16'h004a
) (
  input  logic                 wb_clk_i,
  input  logic                 arst_n_i,
  input  logic [`ZB_ADR_W-1:1] adr_i,
  input  logic [`ZB_DAT_W-1:0] dat_i,
  input  logic                 we_i,
  input  logic [1:0]           sel_i,
  input  logic                 stb_i,
  input  logic                 cyc_i,
  input  logic                 tgc_i,       // inta cycle, answer with the vector
  input  logic                 rand_wait_i, // 0 to 3 wait states per strobe
  output logic [`ZB_DAT_W-1:0] dat_o,
  output logic                 ack_o
);

  logic [7:0]  mem [0:511];
  logic [16:0] lfsr_q;
  logic [16:0] lfsr_a;
  logic [16:0] lfsr_b;
  logic [1:0]  wait_q; // wait states left for the current strobe
  logic [8:0]  lo;
  logic [8:0]  hi;

  // fibonacci, x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  initial
  begin
    for (int i = 0; i < 512; i++)
      mem[i] = 8'((i * 29) ^ (i >> 3)); // every address bit reaches the byte
  end

  assign lo     = {adr_i[8:1], 1'b0};
  assign hi     = {adr_i[8:1], 1'b1};
  assign lfsr_a = lfsr_step(lfsr_q);
  assign lfsr_b = lfsr_step(lfsr_a); // one step per wait bit

  always @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_o  <= 1'b0;
      dat_o  <= '0;
      wait_q <= 2'd0;
      lfsr_q <= SEED;
    end
    else
    begin
      ack_o <= 1'b0; // single cycle ack
      if (stb_i && cyc_i && !ack_o)
      begin
        if (wait_q != 2'd0)
          wait_q <= wait_q - 2'd1;
        else
        begin
          ack_o <= 1'b1;
          if (we_i)
          begin
            if (sel_i[0])
              mem[lo] <= dat_i[7:0];
            if (sel_i[1])
              mem[hi] <= dat_i[15:8];
          end
          else if (tgc_i)
            dat_o <= VECTOR;
          else
            dat_o <= {mem[hi], mem[lo]};
          // waits for the next strobe
          wait_q <= rand_wait_i ? {lfsr_a[0], lfsr_b[0]} : 2'd0;
          lfsr_q <= lfsr_b;
        end
      end
    end
  end

endmodule

/* tests/tb_zet_bus_if.sv */
// directed tests for the bus interface; addresses stay below 0x200, the size of the memory model
`timescale 1ns/10ps
`include "zet_bus_cfg.svh"

module tb_zet_bus_if;

  localparam int          TIMEOUT_CYC = 64;
  localparam logic [15:0] VECTOR      = 16'h004a;

  logic                 wb_clk_i;
  logic                 arst_n_i;
  logic [`ZB_ADR_W-1:0] fetch_adr_i;
  logic [`ZB_ADR_W-1:0] exec_adr_i;
  logic                 fetch_byte_i;
  logic                 exec_byte_i;
  logic                 exec_we_i;
  logic                 exec_io_i;
  logic [`ZB_DAT_W-1:0] exec_dat_i;
  logic                 fetch_or_exec_i;
  logic                 memop_i;
  logic                 inta_i;
  logic [`ZB_DAT_W-1:0] cpu_dat_o;
  logic [`ZB_DAT_W-1:0] iid_dat_o;
  logic                 block_o;
  logic [`ZB_DAT_W-1:0] wb_dat_i;
  logic                 wb_ack_i;
  logic                 wb_tgc_i;
  logic [`ZB_DAT_W-1:0] wb_dat_o;
  logic [`ZB_ADR_W-1:1] wb_adr_o;
  logic                 wb_we_o;
  logic                 wb_tga_o;
  logic [1:0]           wb_sel_o;
  logic                 wb_stb_o;
  logic                 wb_cyc_o;
  logic                 wb_tgc_o;
  logic                 rand_wait;

  logic [7:0]           shadow [0:511]; // expected memory contents
  logic [`ZB_ADR_W-2:0] log_adr [0:3];  // bus address at each ack
  logic [1:0]           log_sel [0:3];
  logic                 log_tga [0:3];
  logic [`ZB_DAT_W-1:0] last_rdat;
  logic [`ZB_DAT_W-1:0] last_iid;
  int                   err_cnt;
  int                   chk_cnt;

  initial
  begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  zet_bus_if DUT (.*);

  wb_mem_model #(.VECTOR(VECTOR)) u_mem (
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .adr_i       (wb_adr_o),
    .dat_i       (wb_dat_o),
    .we_i        (wb_we_o),
    .sel_i       (wb_sel_o),
    .stb_i       (wb_stb_o),
    .cyc_i       (wb_cyc_o),
    .tgc_i       (wb_tgc_o),
    .rand_wait_i (rand_wait),
    .dat_o       (wb_dat_i),
    .ack_o       (wb_ack_i)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // one access, held until the first unblocked cycle after the last ack
  task automatic run_access(input logic use_exec, input logic [`ZB_ADR_W-1:0] adr,
                            input logic byte_op, input logic we, input logic io,
                            input logic [`ZB_DAT_W-1:0] wdat, input int exp_acks);
    int   cycles;
    int   acks;
    logic done;
    cycles = 0;
    acks   = 0;
    done   = 1'b0;
    @(posedge wb_clk_i);
    fetch_or_exec_i <= use_exec;
    fetch_adr_i     <= adr;
    exec_adr_i      <= adr;
    fetch_byte_i    <= byte_op;
    exec_byte_i     <= byte_op;
    exec_we_i       <= we;
    exec_io_i       <= io;
    exec_dat_i      <= wdat;
    memop_i         <= ~io; // i/o goes through exec_io_i alone
    while (!done && cycles < TIMEOUT_CYC)
    begin
      @(negedge wb_clk_i);
      cycles++;
      if (wb_ack_i)
      begin
        if (acks < 4)
        begin
          log_adr[acks] = wb_adr_o;
          log_sel[acks] = wb_sel_o;
          log_tga[acks] = wb_tga_o;
        end
        acks++;
      end
      else if (acks >= exp_acks && !block_o)
        done = 1'b1;
    end
    if (!done)
    begin
      err_cnt++;
      $display("access at 0x%05h did not finish within %0d cycles, %0d ack(s) seen",
               adr, TIMEOUT_CYC, acks);
    end
    check_value("ack count", 32'(acks), 32'(exp_acks));
    last_rdat = cpu_dat_o;
    last_iid  = iid_dat_o;
    @(posedge wb_clk_i);
    memop_i   <= 1'b0;
    exec_io_i <= 1'b0;
    exec_we_i <= 1'b0;
  endtask

  // first byte with the wanted address parity and sign
  function automatic logic [`ZB_ADR_W-1:0] find_byte_addr(input logic odd, input logic neg);
    for (int i = 16; i < 512; i++)
      if (i[0] == odd && shadow[i][7] == neg)
        return 20'(i);
    return 20'h0;
  endfunction

  task automatic compare_memory();
    for (int i = 0; i < 512; i++)
      check_value($sformatf("mem[0x%03h]", i), 32'(u_mem.mem[i]), 32'(shadow[i]));
  endtask

  task automatic idle_after_reset();
    for (int i = 0; i < 6; i++)
    begin
      @(negedge wb_clk_i);
      check_value("wb_stb_o", 32'(wb_stb_o), 32'd0);
      check_value("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
      check_value("block_o", 32'(block_o), 32'd0);
      check_value("cpu_dat_o", 32'(cpu_dat_o), 32'd0);
    end
  endtask

  task automatic fetch_even_word();
    run_access(1'b0, 20'h00040, 1'b0, 1'b0, 1'b0, 16'h0, 1);
    check_value("cpu_dat_o", 32'(last_rdat), 32'({shadow[9'h041], shadow[9'h040]}));
    check_value("wb_sel_o", 32'(log_sel[0]), 32'b11);
    check_value("wb_adr_o", 32'(log_adr[0]), 32'h20);
  endtask

  task automatic exec_byte_reads();
    logic [`ZB_ADR_W-1:0] adr;
    logic [7:0]           b;
    for (int k = 0; k < 4; k++)
    begin
      adr = find_byte_addr(k[0], k[1]); // even/odd, positive/negative
      b   = shadow[adr[8:0]];
      run_access(1'b1, adr, 1'b1, 1'b0, 1'b0, 16'h0, 1);
      check_value("cpu_dat_o", 32'(last_rdat), 32'({{8{b[7]}}, b}));
      check_value("wb_sel_o", 32'(log_sel[0]), adr[0] ? 32'b10 : 32'b01);
    end
  endtask

  task automatic read_odd_word();
    run_access(1'b1, 20'h0007b, 1'b0, 1'b0, 1'b0, 16'h0, 2);
    check_value("cpu_dat_o", 32'(last_rdat), 32'({shadow[9'h07c], shadow[9'h07b]}));
    check_value("wb_sel_o first", 32'(log_sel[0]), 32'b10);
    check_value("wb_adr_o first", 32'(log_adr[0]), 32'h3d);
    check_value("wb_sel_o second", 32'(log_sel[1]), 32'b01);
    check_value("wb_adr_o second", 32'(log_adr[1]), 32'h3e);
  endtask

  task automatic write_accesses();
    logic [8:0]           base;
    logic [`ZB_DAT_W-1:0] wdat;
    @(posedge wb_clk_i);
    rand_wait <= 1'b1;
    for (int j = 0; j < 4; j++)
    begin
      base = 9'h100 + 9'(j * 32);
      wdat = 16'hbe00 | 16'(j * 5 + 1);
      run_access(1'b1, {11'h0, base}, 1'b0, 1'b1, 1'b0, wdat, 1);
      shadow[base]        = wdat[7:0];
      shadow[base + 9'd1] = wdat[15:8];
      run_access(1'b1, {11'h0, base + 9'd9}, 1'b1, 1'b1, 1'b0, ~wdat, 1);
      shadow[base + 9'd9] = ~wdat[7:0]; // byte write only touches one lane
      run_access(1'b1, {11'h0, base + 9'd17}, 1'b0, 1'b1, 1'b0, wdat, 2);
      shadow[base + 9'd17] = wdat[7:0];
      shadow[base + 9'd18] = wdat[15:8];
    end
    compare_memory();
    run_access(1'b1, 20'h00111, 1'b0, 1'b0, 1'b0, 16'h0, 2); // split read back
    check_value("cpu_dat_o", 32'(last_rdat), 32'({shadow[9'h112], shadow[9'h111]}));
  endtask

  task automatic inta_cycle();
    @(posedge wb_clk_i);
    inta_i <= 1'b1;
    @(negedge wb_clk_i);
    check_value("wb_tgc_o", 32'(wb_tgc_o), 32'd1);
    // odd byte, so the read register holds something other than the raw bus word
    run_access(1'b1, 20'h00021, 1'b1, 1'b0, 1'b1, 16'h0, 1);
    check_value("wb_tga_o", 32'(log_tga[0]), 32'd1);
    check_value("iid_dat_o", 32'(last_iid), 32'(VECTOR));
    @(posedge wb_clk_i);
    inta_i <= 1'b0;
    @(negedge wb_clk_i);
    check_value("wb_tgc_o", 32'(wb_tgc_o), 32'd0);
    // sign extended high byte from the read register
    check_value("iid_dat_o", 32'(iid_dat_o), 32'({{8{VECTOR[15]}}, VECTOR[15:8]}));
  endtask

  initial
  begin
    err_cnt         = 0;
    chk_cnt         = 0;
    arst_n_i        = 1'b0;
    fetch_adr_i     = '0;
    exec_adr_i      = '0;
    fetch_byte_i    = 1'b0;
    exec_byte_i     = 1'b0;
    exec_we_i       = 1'b0;
    exec_io_i       = 1'b0;
    exec_dat_i      = '0;
    fetch_or_exec_i = 1'b0;
    memop_i         = 1'b0;
    inta_i          = 1'b0;
    wb_tgc_i        = 1'b0;
    rand_wait       = 1'b0;
    repeat (5) @(posedge wb_clk_i);
    arst_n_i <= 1'b1;
    for (int i = 0; i < 512; i++)
      shadow[i] = u_mem.mem[i];
    idle_after_reset();
    fetch_even_word();
    exec_byte_reads();
    read_odd_word();
    write_accesses();
    inta_cycle();
    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* tb.f */
+incdir+design
design/wb_pkg.sv
design/zet_bus_pkg.sv
design/access_select.sv
design/wb_access_fsm.sv
design/read_assembler.sv
design/zet_bus_if.sv
tests/wb_mem_model.sv
tests/tb_zet_bus_if.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bus interface testbench with Verilator; result comes from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f tb.f \
  --top-module tb_zet_bus_if --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  echo "FAIL"
  exit 1
fi
if ! grep -q "Finished with no errors" "$LOG"; then
  echo "FAIL: no result line in $LOG"
  exit 1
fi
echo "PASS"
exit 0
